//--- src/cpu_if_defines.svh
`ifndef CPU_IF_DEFINES_SVH
`define CPU_IF_DEFINES_SVH

// width of a bus address as seen by the sequencer
`define CPU_IF_ADDR_W 16

// width of one data word on the memory/IO bus
`define CPU_IF_DATA_W 16

// cycles an open bus phase may wait for ok or en before the alarm fires
// counted from the bus_start strobe of that phase
`define CPU_IF_ALARM_DLY 24

// length of the talarm pulse in cycles
// it must stay shorter than the delay so a new phase cannot retrigger a running pulse
`define CPU_IF_ALARM_TICKS 4

`endif

//--- src/cpu_if_pkg.sv
`include "cpu_if_defines.svh"

package cpu_if_pkg;

	// plain vectors for the address and data paths
	typedef logic [`CPU_IF_ADDR_W-1:0] addr_t;
	typedef logic [`CPU_IF_DATA_W-1:0] data_t;

	// kind of transfer asked for by the instruction sequencer
	// both RMW forms keep the bus across the read and the write
	typedef enum logic [1:0] {
		OP_READ,
		OP_WRITE,
		OP_RMW,
		OP_RMW_COND
	} op_e;

	// how a transfer ended, ST_SKIP only for a conditional RMW that found its bits set
	typedef enum logic [1:0] {
		ST_OK,
		ST_EN,
		ST_ALARM,
		ST_SKIP
	} status_e;

	// sequencer state, one phase open at most
	typedef enum logic [1:0] {
		PH_IDLE,
		PH_RD,
		PH_WR,
		PH_DONE
	} phase_e;

	// transfer command as handed in with cmd_valid
	typedef struct packed {
		op_e   op;
		addr_t addr;
		data_t wdata;
	} cmd_t;

	// content of one bus phase
	typedef struct packed {
		logic  wr;
		addr_t addr;
		data_t data;
	} bus_cmd_t;

	// one-cycle answer of the slave, exactly one of ok or en is set
	typedef struct packed {
		logic  ok;
		logic  en;
		data_t rdata;
	} bus_rsp_t;

	// what goes back to the sequencer together with done
	typedef struct packed {
		status_e status;
		data_t   rdata;
	} result_t;

endpackage

//--- src/alarm_timer.sv
`timescale 1ns/100ps

module alarm_timer #(
	parameter int DELAY = 16,
	parameter int PULSE = 4
) (
	input  logic __clk,
	input  logic rst_n,
	input  logic arm,
	output logic alarm
);

	// the delay counter stops at DELAY so one arming gives one pulse only
	localparam int DW = $clog2(DELAY + 1);
	localparam int PW = $clog2(PULSE + 1);

	logic [DW-1:0] delay_cnt;
	logic [PW-1:0] pulse_cnt;
	logic          fire;

	// delay_cnt equals the number of armed cycles seen so far
	// so the pulse is loaded on the last edge before cycle DELAY of the arming
	assign fire = arm && (delay_cnt == DW'(DELAY - 1));

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			delay_cnt <= '0;
		end else if (!arm) begin
			// a dropped arm means the answer came, start over for the next phase
			delay_cnt <= '0;
		end else if (delay_cnt != DW'(DELAY)) begin
			delay_cnt <= delay_cnt + 1'b1;
		end
	end

	// one-shot part, runs on its own once loaded even after arm falls
	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			pulse_cnt <= '0;
		end else if (fire) begin
			pulse_cnt <= PW'(PULSE);
		end else if (pulse_cnt != '0) begin
			pulse_cnt <= pulse_cnt - 1'b1;
		end
	end

	assign alarm = (pulse_cnt != '0);

	// the pulse has a fixed length whatever arm does meanwhile
	a_pulse_len: assert property (
		@(posedge __clk) disable iff (!rst_n)
		$rose(alarm) |-> alarm[*PULSE] ##1 !alarm
	);

endmodule

//--- src/if_ctl.sv
`timescale 1ns/100ps
`include "cpu_if_defines.svh"

module if_ctl (
	input  logic                  __clk,
	input  logic                  rst_n,
	input  logic                  phase_go,
	input  cpu_if_pkg::bus_cmd_t  phase_cmd,
	input  logic                  hold,
	input  logic                  rsp_valid,
	input  cpu_if_pkg::bus_rsp_t  rsp,
	output logic                  bus_req,
	output logic                  bus_start,
	output cpu_if_pkg::bus_cmd_t  bus_cmd,
	output logic                  talarm,
	output logic                  phase_end,
	output cpu_if_pkg::status_e   phase_status,
	output cpu_if_pkg::data_t     rdata
);

	// zgi is the open-phase flag, it is set by phase_go and cleared by the answer
	logic                 zgi;
	logic                 talarm_q;
	logic                 alarm_rise;
	logic                 close;
	logic                 arm;
	cpu_if_pkg::bus_cmd_t cmd_q;

	// only the rising edge of the alarm ends a phase
	// the tail of the pulse may overlap the start of the next transfer
	assign alarm_rise = talarm && !talarm_q;

	// answers outside an open phase are dropped here
	assign close = zgi && (rsp_valid || alarm_rise);

	// the timer runs while a phase waits for its answer
	// the answer cycle drops arm so a following write phase counts from zero
	assign arm = phase_go || (zgi && !rsp_valid);

	// request covers the start cycle, the open phase and the RMW hold
	// a pending start is what bridges the read answer and the write strobe
	assign bus_req = phase_go || zgi || hold;
	assign bus_start = phase_go;

	// the command is on the bus from its own start strobe onward
	assign bus_cmd = phase_go ? phase_cmd : cmd_q;

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			zgi <= 1'b0;
			phase_end <= 1'b0;
			talarm_q <= 1'b0;
		end else begin
			if (phase_go) begin
				zgi <= 1'b1;
			end else if (close) begin
				zgi <= 1'b0;
			end
			// phase_end plays the part of ok$, one cycle for any ending
			phase_end <= close;
			talarm_q <= talarm;
		end
	end

	always_ff @(posedge __clk) begin
		if (phase_go) begin
			cmd_q <= phase_cmd;
		end
		if (close) begin
			// an answer wins over an alarm that rises in the same cycle
			if (rsp_valid) begin
				phase_status <= rsp.ok ? cpu_if_pkg::ST_OK : cpu_if_pkg::ST_EN;
			end else begin
				phase_status <= cpu_if_pkg::ST_ALARM;
			end
			// refused or silent phases hand back zero instead of stale data
			rdata <= (rsp_valid && rsp.ok) ? rsp.rdata : '0;
		end
	end

	alarm_timer #(
		.DELAY(`CPU_IF_ALARM_DLY),
		.PULSE(`CPU_IF_ALARM_TICKS)
	) alarm_timer_i (
		.__clk(__clk),
		.rst_n(rst_n),
		.arm(arm),
		.alarm(talarm)
	);

	// the sequencer's hold must carry the request into the next cycle
	// unless the phase is being closed right now
	a_hold_keeps_req: assert property (
		@(posedge __clk) disable iff (!rst_n)
		(hold && !close) |=> bus_req
	);

	// the slave must pick one answer per phase
	a_rsp_onehot: assert property (
		@(posedge __clk) disable iff (!rst_n)
		rsp_valid |-> (rsp.ok ^ rsp.en)
	);

endmodule

//--- src/cycle_seq.sv
`timescale 1ns/100ps

module cycle_seq (
	input  logic                  __clk,
	input  logic                  rst_n,
	input  logic                  cmd_valid,
	input  cpu_if_pkg::cmd_t      cmd,
	input  logic                  phase_end,
	input  cpu_if_pkg::status_e   phase_status,
	input  cpu_if_pkg::data_t     rdata,
	output logic                  busy,
	output logic                  phase_go,
	output cpu_if_pkg::bus_cmd_t  phase_cmd,
	output logic                  hold,
	output logic                  done,
	output cpu_if_pkg::result_t   result
);

	cpu_if_pkg::phase_e  state;
	cpu_if_pkg::cmd_t    cmd_q;
	cpu_if_pkg::data_t   rd_q;
	cpu_if_pkg::data_t   wr_word;
	cpu_if_pkg::status_e fin_status;
	logic                go_q;
	logic                is_rmw;
	logic                bits_clear;
	logic                rd_ok;
	logic                wr_go;

	assign is_rmw = (cmd_q.op == cpu_if_pkg::OP_RMW) || (cmd_q.op == cpu_if_pkg::OP_RMW_COND);

	// conditional case, write only if none of the wdata bits are already set
	assign bits_clear = ((rdata & cmd_q.wdata) == '0);

	// read phase just closed with ok, rdata already holds the word
	assign rd_ok = (state == cpu_if_pkg::PH_RD) && phase_end &&
		(phase_status == cpu_if_pkg::ST_OK);

	// the write of an RMW starts in the same cycle the read ends
	// so the bus request has no gap between the two phases
	assign wr_go = rd_ok && ((cmd_q.op == cpu_if_pkg::OP_RMW) ||
		((cmd_q.op == cpu_if_pkg::OP_RMW_COND) && bits_clear));

	assign phase_go = go_q || wr_go;

	// plain writes send wdata, RMW writes send the merged word
	assign wr_word = (cmd_q.op == cpu_if_pkg::OP_WRITE) ? cmd_q.wdata : (rdata | cmd_q.wdata);

	assign phase_cmd = '{
		wr:   (state == cpu_if_pkg::PH_WR) || wr_go,
		addr: cmd_q.addr,
		data: wr_word
	};

	// keeps the request through the read of an atomic transfer
	// and lets it go at once when the read ends without a write
	assign hold = (state == cpu_if_pkg::PH_RD) && is_rmw && (!phase_end || wr_go);

	assign busy = (state != cpu_if_pkg::PH_IDLE);

	// every phase end is final except a read that hands over to the write
	assign done = phase_end && !wr_go;

	always_comb begin
		fin_status = phase_status;
		if (rd_ok && (cmd_q.op == cpu_if_pkg::OP_RMW_COND) && !bits_clear) begin
			fin_status = cpu_if_pkg::ST_SKIP;
		end
	end

	// reads report the fresh word, RMW writes report the word they read
	assign result = '{
		status: fin_status,
		rdata:  (state == cpu_if_pkg::PH_RD) ? rdata : rd_q
	};

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			state <= cpu_if_pkg::PH_IDLE;
			go_q <= 1'b0;
		end else begin
			go_q <= 1'b0;
			case (state)
				cpu_if_pkg::PH_IDLE: begin
					// strobes that come while busy never reach this branch and are lost
					if (cmd_valid) begin
						go_q <= 1'b1;
						if (cmd.op == cpu_if_pkg::OP_WRITE) begin
							state <= cpu_if_pkg::PH_WR;
						end else begin
							state <= cpu_if_pkg::PH_RD;
						end
					end
				end
				cpu_if_pkg::PH_RD: begin
					if (wr_go) begin
						state <= cpu_if_pkg::PH_WR;
					end else if (phase_end) begin
						state <= cpu_if_pkg::PH_DONE;
					end
				end
				cpu_if_pkg::PH_WR: begin
					if (phase_end) begin
						state <= cpu_if_pkg::PH_DONE;
					end
				end
				// one idle bus cycle before the next command is taken
				default: begin
					state <= cpu_if_pkg::PH_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge __clk) begin
		if ((state == cpu_if_pkg::PH_IDLE) && cmd_valid) begin
			cmd_q <= cmd;
			// a plain write has no read word to report
			rd_q <= '0;
		end else if ((state == cpu_if_pkg::PH_RD) && phase_end) begin
			rd_q <= rdata;
		end
	end

	// phase_end comes from the bus side and may only close a phase we opened
	a_done_in_phase: assert property (
		@(posedge __clk) disable iff (!rst_n)
		done |-> (state != cpu_if_pkg::PH_IDLE)
	);

endmodule

//--- src/cpu_if.sv
`timescale 1ns/100ps

module cpu_if (
	input  logic                  __clk,
	input  logic                  rst_n,
	input  logic                  cmd_valid,
	input  cpu_if_pkg::cmd_t      cmd,
	output logic                  busy,
	output logic                  done,
	output cpu_if_pkg::result_t   result,
	output logic                  bus_req,
	output logic                  bus_start,
	output cpu_if_pkg::bus_cmd_t  bus_cmd,
	input  logic                  rsp_valid,
	input  cpu_if_pkg::bus_rsp_t  rsp,
	output logic                  talarm
);

	// sequencer to bus controller
	logic                 phase_go;
	cpu_if_pkg::bus_cmd_t phase_cmd;
	logic                 hold;

	// bus controller back to the sequencer
	logic                 phase_end;
	cpu_if_pkg::status_e  phase_status;
	cpu_if_pkg::data_t    rdata;

	// command side, walks the read and write phases of a transfer
	cycle_seq cycle_seq_i (
		.__clk(__clk),
		.rst_n(rst_n),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.phase_end(phase_end),
		.phase_status(phase_status),
		.rdata(rdata),
		.busy(busy),
		.phase_go(phase_go),
		.phase_cmd(phase_cmd),
		.hold(hold),
		.done(done),
		.result(result)
	);

	// bus side, request, answer capture and the no-answer alarm
	if_ctl if_ctl_i (
		.__clk(__clk),
		.rst_n(rst_n),
		.phase_go(phase_go),
		.phase_cmd(phase_cmd),
		.hold(hold),
		.rsp_valid(rsp_valid),
		.rsp(rsp),
		.bus_req(bus_req),
		.bus_start(bus_start),
		.bus_cmd(bus_cmd),
		.talarm(talarm),
		.phase_end(phase_end),
		.phase_status(phase_status),
		.rdata(rdata)
	);

endmodule

//--- dv/if_responder.sv
`timescale 1ns/100ps
`include "cpu_if_defines.svh"

module if_responder (
	input  logic                 clk,
	input  logic                 bus_start,
	input  cpu_if_pkg::bus_cmd_t bus_cmd,
	output logic                 rsp_valid,
	output cpu_if_pkg::bus_rsp_t rsp,
	output logic [1:0]           ans_kind,
	output logic                 ans_strobe
);

	// answer kinds, published to the testbench model once per phase
	localparam logic [1:0] KIND_OK = 2'd0;
	localparam logic [1:0] KIND_EN = 2'd1;
	localparam logic [1:0] KIND_SILENT = 2'd2;

	// small memory behind the bus, the testbench fills it before reset ends
	logic [`CPU_IF_DATA_W-1:0] mem [64];

	cpu_if_pkg::bus_cmd_t cmd_q;
	logic [1:0]           kind_q;
	logic [3:0]           cnt;
	logic                 pending;
	int unsigned          r;

	initial begin
		rsp_valid = 1'b0;
		rsp = '0;
		ans_kind = KIND_OK;
		ans_strobe = 1'b0;
		pending = 1'b0;
		cnt = '0;
	end

	always @(posedge clk) begin
		rsp_valid <= 1'b0;
		rsp <= '0;
		ans_strobe <= 1'b0;
		if (bus_start) begin
			// one in sixteen stays silent, two in sixteen refuse
			r = $urandom % 16;
			kind_q <= (r == 0) ? KIND_SILENT : ((r <= 2) ? KIND_EN : KIND_OK);
			ans_kind <= (r == 0) ? KIND_SILENT : ((r <= 2) ? KIND_EN : KIND_OK);
			ans_strobe <= 1'b1;
			pending <= (r != 0);
			cnt <= 4'($urandom_range(1, 8));
			cmd_q <= bus_cmd;
		end else if (pending) begin
			if (cnt == 4'd1) begin
				pending <= 1'b0;
				rsp_valid <= 1'b1;
				rsp.ok <= (kind_q == KIND_OK);
				rsp.en <= (kind_q == KIND_EN);
				rsp.rdata <= mem[cmd_q.addr[5:0]];
				if (kind_q == KIND_OK && cmd_q.wr)
					mem[cmd_q.addr[5:0]] = cmd_q.data;
			end else begin
				cnt <= cnt - 4'd1;
			end
		end
	end

endmodule

//--- dv/tb_cpu_if.sv
`timescale 1ns/100ps
`include "cpu_if_defines.svh"

module tb_cpu_if;

	localparam int N_CMDS = 300;
	localparam int LIMIT = N_CMDS * 2 * (`CPU_IF_ALARM_DLY + `CPU_IF_ALARM_TICKS + 4) + 100;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	logic cmd_valid = 1'b0;
	cpu_if_pkg::cmd_t cmd = '0;
	logic busy, done, bus_req, bus_start, rsp_valid, talarm, ans_strobe;
	cpu_if_pkg::result_t  result;
	cpu_if_pkg::bus_cmd_t bus_cmd;
	cpu_if_pkg::bus_rsp_t rsp;
	logic [1:0] ans_kind;

	// model state and bus monitor bookkeeping
	cpu_if_pkg::data_t model_mem [64];
	cpu_if_pkg::cmd_t cur_cmd = '0;
	logic [1:0] kinds [$];
	int cyc = 0;
	int n_starts = 0;
	int last_start = 0;
	int rise_cyc = -100;
	int pulse_len = 0;
	logic in_xfer = 1'b0;
	logic talarm_d = 1'b0;

	always #20 clk = ~clk;

	cpu_if cpu_if_i (
		.__clk(clk), .rst_n(rst_n), .cmd_valid(cmd_valid), .cmd(cmd),
		.busy(busy), .done(done), .result(result), .bus_req(bus_req),
		.bus_start(bus_start), .bus_cmd(bus_cmd), .rsp_valid(rsp_valid),
		.rsp(rsp), .talarm(talarm)
	);

	if_responder resp_i (
		.clk(clk), .bus_start(bus_start), .bus_cmd(bus_cmd), .rsp_valid(rsp_valid),
		.rsp(rsp), .ans_kind(ans_kind), .ans_strobe(ans_strobe)
	);

	task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (exp === act) else begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	// answer kind of one phase turned into the status it should end with
	function automatic cpu_if_pkg::status_e kind_status(input logic [1:0] k);
		return (k == 2'd0) ? cpu_if_pkg::ST_OK :
			((k == 2'd1) ? cpu_if_pkg::ST_EN : cpu_if_pkg::ST_ALARM);
	endfunction

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (ans_strobe)
			kinds.push_back(ans_kind);
		if (cmd_valid && !busy)
			n_starts <= 0;
		else if (bus_start)
			n_starts <= n_starts + 1;
		if (bus_start) begin
			last_start <= cyc;
			in_xfer <= 1'b1;
			// every phase goes to the command's address and only a WRITE or a second phase writes
			check_eq("bus_cmd.addr", cur_cmd.addr, bus_cmd.addr);
			check_eq("bus_cmd.wr", (cur_cmd.op == cpu_if_pkg::OP_WRITE) || (n_starts != 0),
				bus_cmd.wr);
		end else if (done) begin
			in_xfer <= 1'b0;
		end
		// request must stay up from the first strobe until done
		if (in_xfer && !done)
			check_eq("bus_req", 1, bus_req);
	end

	// alarm pulse position and length
	always @(posedge clk) begin
		talarm_d <= talarm;
		if (talarm && !talarm_d) begin
			rise_cyc <= cyc;
			check_eq("talarm delay", `CPU_IF_ALARM_DLY, cyc - last_start);
		end
		pulse_len <= talarm ? pulse_len + 1 : 0;
		if (!talarm && talarm_d)
			check_eq("talarm length", `CPU_IF_ALARM_TICKS, pulse_len);
	end

	initial begin
		repeat (LIMIT) @(posedge clk);
		$display("timeout, the run did not finish within %0d cycles", LIMIT);
		$display("TEST FAILED");
		$fatal(1);
	end

	initial begin
		cpu_if_pkg::cmd_t c;
		cpu_if_pkg::status_e exp_status;
		cpu_if_pkg::data_t old;
		int exp_n;
		logic chk_rd;
		void'($urandom(32'h6e04b241));
		for (int i = 0; i < 64; i++) begin
			model_mem[i] = cpu_if_pkg::data_t'($urandom);
			resp_i.mem[i] = model_mem[i];
		end
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		check_eq("bus_req", 0, bus_req);
		check_eq("busy", 0, busy);
		check_eq("done", 0, done);
		check_eq("talarm", 0, talarm);
		for (int n = 0; n < N_CMDS; n++) begin
			while (busy)
				@(posedge clk);
			c.op = cpu_if_pkg::op_e'($urandom % 4);
			c.addr = cpu_if_pkg::addr_t'($urandom);
			// single bits make a conditional skip or write equally likely
			c.wdata = ($urandom % 2) ? cpu_if_pkg::data_t'(1 << ($urandom % 16)) :
				cpu_if_pkg::data_t'($urandom);
			old = model_mem[c.addr[5:0]];
			cur_cmd = c;
			cmd_valid <= 1'b1;
			cmd <= c;
			@(posedge clk);
			cmd_valid <= 1'b0;
			@(posedge clk);
			// a strobe while busy must be dropped
			if (busy && ($urandom % 2)) begin
				cmd_valid <= 1'b1;
				cmd <= cpu_if_pkg::cmd_t'({$urandom, $urandom});
				@(posedge clk);
				cmd_valid <= 1'b0;
			end
			do @(posedge clk); while (!done);
			exp_n = 1;
			chk_rd = (c.op != cpu_if_pkg::OP_WRITE);
			exp_status = kind_status(kinds[0]);
			if (c.op == cpu_if_pkg::OP_WRITE && exp_status == cpu_if_pkg::ST_OK) begin
				model_mem[c.addr[5:0]] = c.wdata;
			end else if (c.op >= cpu_if_pkg::OP_RMW && exp_status == cpu_if_pkg::ST_OK) begin
				if (c.op == cpu_if_pkg::OP_RMW_COND && (old & c.wdata) != 0) begin
					exp_status = cpu_if_pkg::ST_SKIP;
				end else begin
					exp_n = 2;
					check_eq("bus_start count", exp_n, kinds.size());
					exp_status = kind_status(kinds[1]);
					if (exp_status == cpu_if_pkg::ST_OK)
						model_mem[c.addr[5:0]] = old | c.wdata;
				end
			end
			check_eq("bus_start count", exp_n, kinds.size());
			check_eq("bus_start count", exp_n, n_starts);
			check_eq("result.status", exp_status, result.status);
			if (chk_rd && (exp_status == cpu_if_pkg::ST_OK || exp_status == cpu_if_pkg::ST_SKIP))
				check_eq("result.rdata", old, result.rdata);
			if (exp_status == cpu_if_pkg::ST_ALARM)
				check_eq("done after talarm", rise_cyc + 1, cyc);
			kinds.delete();
		end
		repeat (8) @(posedge clk);
		for (int i = 0; i < 64; i++)
			check_eq($sformatf("mem[%0d]", i), model_mem[i], resp_i.mem[i]);
		$display("TEST OK");
		$finish;
	end

endmodule

//--- build.f
+incdir+src
src/cpu_if_pkg.sv
src/alarm_timer.sv
src/if_ctl.sv
src/cycle_seq.sv
src/cpu_if.sv
dv/if_responder.sv
dv/tb_cpu_if.sv

//--- Makefile
# Verilator build and run of the cpu_if testbench

VERILATOR ?= verilator
TOP       ?= tb_cpu_if
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
SEED_ARGS ?= +verilator+seed+1
TIMEOUT   ?= 600

VFLAGS ?= --binary --timing --assert -Wall -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(wildcard src/*) $(wildcard dv/*)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	timeout $(TIMEOUT) ./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS)

clean:
	rm -rf $(OBJ_DIR)
